// File: rtl/fetch_pkg.sv
// Shared widths and constants of the fetch stage
// Fixed 32-bit words, no compressed instructions, so the PC always steps by one word
`default_nettype none

package fetch_pkg;

    // Byte address, used for targets, instruction address and PC
    typedef logic [31:0] addr_t;

    // Word address, bits 31:2 of a byte address
    typedef logic [29:0] word_addr_t;

    // Instruction word as returned by memory
    typedef logic [31:0] instr_t;

    // addi x0, x0, 0
    // Issued after reset and flush
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // PC step per issued instruction
    localparam logic [2:0] WORD_BYTES = 3'd4;

endpackage

`default_nettype wire

// File: rtl/fetch_addr_gen.sv
// Stage 1 of the fetch path, next-address selection and instruction address register
// A redirect loads its target even while enable_i is low; ctx switch wins over jump
// START_ADDRESS is word aligned here whatever its low bits are
`default_nettype none

module fetch_addr_gen #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000
) (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             sys_reset_i,
    input  wire logic             enable_i,
    input  wire logic             jump_i,
    input  wire fetch_pkg::addr_t jump_target_i,
    input  wire logic             ctx_switch_i,
    input  wire fetch_pkg::addr_t ctx_switch_target_i,
    output logic                  redirect_o,
    output fetch_pkg::addr_t      instruction_address_o
);

    localparam fetch_pkg::addr_t START_ALIGNED = {START_ADDRESS[31:2], 2'b00};

    fetch_pkg::word_addr_t cur_word;
    fetch_pkg::word_addr_t advance_word;
    fetch_pkg::word_addr_t next_word;

    ////////////////////////////////////////////////////////////
    // Next address selection
    ////////////////////////////////////////////////////////////

    assign redirect_o   = jump_i || ctx_switch_i;
    assign cur_word     = instruction_address_o[31:2];
    assign advance_word = cur_word + fetch_pkg::word_addr_t'(1);

    always_comb begin
        if (ctx_switch_i) begin
            next_word = ctx_switch_target_i[31:2];
        end else if (jump_i) begin
            next_word = jump_target_i[31:2];
        end else begin
            next_word = advance_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction address register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_address_o <= START_ALIGNED;
        end else if (sys_reset_i) begin
            instruction_address_o <= START_ALIGNED;
        end else if (redirect_o || enable_i) begin
            // Low bits always cleared, only whole words are fetched
            instruction_address_o <= {next_word, 2'b00};
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_redirect.sv
// Stage 2 of the fetch path that tracks why and where the fetch redirected
// Reset and sys_reset_i count as a redirect to START_ADDRESS
// jumping_o stays high until the first word of the new stream is issued
`default_nettype none

module fetch_redirect #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000
) (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             sys_reset_i,
    input  wire logic             enable_i,
    input  wire logic             redirect_i,
    input  wire logic             jump_i,
    input  wire fetch_pkg::addr_t jump_target_i,
    input  wire logic             ctx_switch_i,
    input  wire fetch_pkg::addr_t ctx_switch_target_i,
    output logic                  pc_load_o,
    output fetch_pkg::addr_t      pc_target_o,
    output logic                  jumping_o
);

    localparam int OFFSET_BITS = $clog2(fetch_pkg::WORD_BYTES);

    typedef enum logic [1:0] {
        NONE,
        CTX_SWITCH,
        JUMP
    } redirect_reason_t;

    redirect_reason_t      reason;
    redirect_reason_t      reason_r;
    fetch_pkg::word_addr_t ctx_target_r;
    fetch_pkg::word_addr_t jump_target_r;
    fetch_pkg::word_addr_t target_sel;
    fetch_pkg::word_addr_t target_r;
    logic                  jumped_r;

    ////////////////////////////////////////////////////////////
    // Reason and target capture
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctx_switch_i) begin
            reason = CTX_SWITCH;
        end else if (jump_i) begin
            reason = JUMP;
        end else begin
            reason = NONE;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reason_r      <= NONE;
            ctx_target_r  <= START_ADDRESS[31:OFFSET_BITS];
            jump_target_r <= START_ADDRESS[31:OFFSET_BITS];
        end else if (sys_reset_i) begin
            // NONE selects the jump target, which now points at the start
            reason_r      <= NONE;
            jump_target_r <= START_ADDRESS[31:OFFSET_BITS];
        end else begin
            // Reason kept from the last redirect until the next one
            if (reason != NONE) begin
                reason_r <= reason;
            end
            if (ctx_switch_i) begin
                ctx_target_r <= ctx_switch_target_i[31:OFFSET_BITS];
            end
            if (jump_i) begin
                jump_target_r <= jump_target_i[31:OFFSET_BITS];
            end
        end
    end

    assign target_sel = (reason_r == CTX_SWITCH) ? ctx_target_r : jump_target_r;

    // Held until the new stream reaches the PC register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            target_r <= START_ADDRESS[31:OFFSET_BITS];
        end else if (jumped_r) begin
            target_r <= target_sel;
        end
    end

    assign pc_target_o = {target_r, {OFFSET_BITS{1'b0}}};

    ////////////////////////////////////////////////////////////
    // Flag pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r  <= 1'b1;
            pc_load_o <= 1'b1;
            jumping_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r  <= 1'b1;
            pc_load_o <= 1'b1;
            jumping_o <= 1'b1;
        end else begin
            if (redirect_i) begin
                jumped_r <= 1'b1;
            end else if (enable_i) begin
                jumped_r <= 1'b0;
            end

            // Marks the first issue of the redirected stream
            if (enable_i) begin
                pc_load_o <= jumped_r;
            end

            if (redirect_i || jumped_r) begin
                jumping_o <= 1'b1;
            end else if (enable_i) begin
                jumping_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_issue.sv
// Stage 3 of the fetch path, captures the memory word and issues it with its PC
// Memory returns the word one cycle after the address; a word arriving on the
// first stalled cycle is held until the stage resumes
`default_nettype none

module fetch_issue #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              sys_reset_i,
    input  wire logic              enable_i,
    input  wire fetch_pkg::instr_t instruction_data_i,
    input  wire logic              pc_load_i,
    input  wire fetch_pkg::addr_t  pc_target_i,
    output fetch_pkg::instr_t      instruction_o,
    output fetch_pkg::addr_t       pc_o
);

    localparam fetch_pkg::addr_t PC_STEP = fetch_pkg::addr_t'(fetch_pkg::WORD_BYTES);

    logic              enable_r;
    fetch_pkg::instr_t idata_held;
    fetch_pkg::instr_t idata_sel;
    fetch_pkg::addr_t  pc_next;

    ////////////////////////////////////////////////////////////
    // Held data path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // Word on the bus when the stall starts
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held <= fetch_pkg::NOP_INSTR;
        end else if (sys_reset_i) begin
            idata_held <= fetch_pkg::NOP_INSTR;
        end else if (!enable_i && enable_r) begin
            idata_held <= instruction_data_i;
        end
    end

    // After a stall the live bus no longer carries the pending word
    assign idata_sel = enable_r ? instruction_data_i : idata_held;

    ////////////////////////////////////////////////////////////
    // Instruction and PC registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= fetch_pkg::NOP_INSTR;
        end else if (sys_reset_i) begin
            instruction_o <= fetch_pkg::NOP_INSTR;
        end else if (enable_i) begin
            instruction_o <= idata_sel;
        end
    end

    assign pc_next = pc_load_i ? pc_target_i : pc_o + PC_STEP;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= START_ADDRESS;
        end else if (sys_reset_i) begin
            pc_o <= START_ADDRESS;
        end else if (enable_i) begin
            pc_o <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
// Instruction fetch, three stages joined by plain wires
// Synchronous memory with one cycle of read latency, stalled by enable_i low
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::addr_t START_ADDRESS = 32'h0000_0000
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              sys_reset_i,
    input  wire logic              enable_i,
    input  wire logic              jump_i,
    input  wire fetch_pkg::addr_t  jump_target_i,
    input  wire logic              ctx_switch_i,
    input  wire fetch_pkg::addr_t  ctx_switch_target_i,
    input  wire fetch_pkg::instr_t instruction_data_i,
    output fetch_pkg::addr_t       instruction_address_o,
    output logic                   jumping_o,
    output fetch_pkg::instr_t      instruction_o,
    output fetch_pkg::addr_t       pc_o
);

    logic             redirect;
    logic             pc_load;
    fetch_pkg::addr_t pc_target;

    fetch_addr_gen #(
        .START_ADDRESS(START_ADDRESS)
    ) u_addr_gen (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sys_reset_i          (sys_reset_i),
        .enable_i             (enable_i),
        .jump_i               (jump_i),
        .jump_target_i        (jump_target_i),
        .ctx_switch_i         (ctx_switch_i),
        .ctx_switch_target_i  (ctx_switch_target_i),
        .redirect_o           (redirect),
        .instruction_address_o(instruction_address_o)
    );

    fetch_redirect #(
        .START_ADDRESS(START_ADDRESS)
    ) u_redirect (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset_i        (sys_reset_i),
        .enable_i           (enable_i),
        .redirect_i         (redirect),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .ctx_switch_i       (ctx_switch_i),
        .ctx_switch_target_i(ctx_switch_target_i),
        .pc_load_o          (pc_load),
        .pc_target_o        (pc_target),
        .jumping_o          (jumping_o)
    );

    fetch_issue #(
        .START_ADDRESS(START_ADDRESS)
    ) u_issue (
        .clk               (clk),
        .reset_n           (reset_n),
        .sys_reset_i       (sys_reset_i),
        .enable_i          (enable_i),
        .instruction_data_i(instruction_data_i),
        .pc_load_i         (pc_load),
        .pc_target_i       (pc_target),
        .instruction_o     (instruction_o),
        .pc_o              (pc_o)
    );

endmodule

`default_nettype wire

// File: bench/fetch_properties.sv
// Concurrent checks on the fetch_top ports that bind attaches to every fetch_top instance
// Cycles with a redirect or sys_reset_i are left out of the stall stability check
`default_nettype none

module fetch_properties (
    input wire logic              clk,
    input wire logic              reset_n,
    input wire logic              sys_reset_i,
    input wire logic              enable_i,
    input wire logic              jump_i,
    input wire logic              ctx_switch_i,
    input wire fetch_pkg::addr_t  instruction_address_o,
    input wire logic              jumping_o,
    input wire fetch_pkg::instr_t instruction_o,
    input wire fetch_pkg::addr_t  pc_o
);

    // Number of failed checks
    int assert_failures = 0;

    // Only whole words are fetched
    addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        instruction_address_o[1:0] == 2'b00)
        else begin
            $error("instruction address is not word aligned");
            assert_failures++;
        end

    stall_holds: assert property (@(posedge clk) disable iff (!reset_n)
        (!enable_i && !jump_i && !ctx_switch_i && !sys_reset_i) |=>
            ($stable(instruction_address_o) && $stable(instruction_o) && $stable(pc_o)))
        else begin
            $error("outputs moved while the fetch was stalled");
            assert_failures++;
        end

    // Stale words in flight after any redirect
    redirect_flags: assert property (@(posedge clk) disable iff (!reset_n)
        (jump_i || ctx_switch_i) |=> jumping_o)
        else begin
            $error("jumping_o low in the cycle after a redirect");
            assert_failures++;
        end

endmodule

bind fetch_top fetch_properties u_properties (
    .clk                  (clk),
    .reset_n              (reset_n),
    .sys_reset_i          (sys_reset_i),
    .enable_i             (enable_i),
    .jump_i               (jump_i),
    .ctx_switch_i         (ctx_switch_i),
    .instruction_address_o(instruction_address_o),
    .jumping_o            (jumping_o),
    .instruction_o        (instruction_o),
    .pc_o                 (pc_o)
);

`default_nettype wire

// File: bench/fetch_tb.sv
// Testbench for fetch_top with a memory model of one cycle read latency
// Word at address A is A xor 0xA5A5_0000; stall lengths are random with a fixed seed
// A table row with expected PC SEQ_PC continues the current stream
`default_nettype none

module fetch_tb;

    localparam fetch_pkg::addr_t START = 32'h0000_0100;
    localparam fetch_pkg::addr_t SEQ_PC = 32'hffff_ffff;
    localparam int STEP = fetch_pkg::WORD_BYTES;
    localparam int NUM_ROWS = 13;
    localparam int MAX_HOLD = 12;
    localparam int WATCHDOG_TIME = (NUM_ROWS * (MAX_HOLD + 20) + 8) * 10;

    logic              clk;
    logic              reset_n;
    logic              sys_reset_i;
    logic              enable_i;
    logic              jump_i;
    fetch_pkg::addr_t  jump_target_i;
    logic              ctx_switch_i;
    fetch_pkg::addr_t  ctx_switch_target_i;
    fetch_pkg::instr_t instruction_data_i;
    fetch_pkg::addr_t  instruction_address_o;
    logic              jumping_o;
    fetch_pkg::instr_t instruction_o;
    fetch_pkg::addr_t  pc_o;

    // Stimulus table with one array per column
    string             row_name [NUM_ROWS];
    logic              row_en   [NUM_ROWS];
    logic              row_jump [NUM_ROWS];
    fetch_pkg::addr_t  row_jt   [NUM_ROWS];
    logic              row_ctx  [NUM_ROWS];
    fetch_pkg::addr_t  row_ct   [NUM_ROWS];
    logic              row_srst [NUM_ROWS];
    int                row_hold [NUM_ROWS];
    fetch_pkg::addr_t  row_exp  [NUM_ROWS];

    // Inputs of the cycle just ended and the outputs seen before it
    logic              drv_en;
    logic              drv_redirect;
    logic              drv_srst;
    fetch_pkg::addr_t  drv_target;
    fetch_pkg::addr_t  last_pc;
    fetch_pkg::instr_t last_instr;
    logic              last_jumping;
    fetch_pkg::addr_t  mem_addr_q;
    string             row_label;
    integer            seed;
    int                row_errors;
    int                pass_count;
    int                fail_count;

    fetch_top #(
        .START_ADDRESS(START)
    ) u_dut (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sys_reset_i          (sys_reset_i),
        .enable_i             (enable_i),
        .jump_i               (jump_i),
        .jump_target_i        (jump_target_i),
        .ctx_switch_i         (ctx_switch_i),
        .ctx_switch_target_i  (ctx_switch_target_i),
        .instruction_data_i   (instruction_data_i),
        .instruction_address_o(instruction_address_o),
        .jumping_o            (jumping_o),
        .instruction_o        (instruction_o),
        .pc_o                 (pc_o)
    );

    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Address seen in one cycle returns its word in the next
    initial begin
        instruction_data_i = fetch_pkg::NOP_INSTR;
        mem_addr_q = START;
        forever begin
            @(negedge clk);
            instruction_data_i = mem_word(mem_addr_q);
            mem_addr_q = instruction_address_o;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Run timed out after %0d time units before all tests finished", WATCHDOG_TIME);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s expected %h actual %h", row_label, sig, exp, act);
            row_errors++;
        end
    endtask

    task automatic observe();
        if (drv_srst) begin
            check_value("instruction_address_o", START, instruction_address_o);
            check_value("jumping_o", 32'd1, jumping_o);
            check_value("instruction_o", fetch_pkg::NOP_INSTR, instruction_o);
            check_value("pc_o", START, pc_o);
        end else if (drv_redirect) begin
            check_value("instruction_address_o", drv_target, instruction_address_o);
            check_value("jumping_o", 32'd1, jumping_o);
        end else if (!drv_en) begin
            check_value("pc_o", last_pc, pc_o);
            check_value("instruction_o", last_instr, instruction_o);
            check_value("jumping_o", last_jumping, jumping_o);
        end
        // Valid issues follow the memory rule and the word step
        if (!jumping_o && !drv_srst) begin
            check_value("instruction_o", mem_word(pc_o), instruction_o);
            if (!last_jumping && drv_en) begin
                check_value("pc_o", last_pc + STEP, pc_o);
            end
        end
        last_pc = pc_o;
        last_instr = instruction_o;
        last_jumping = jumping_o;
    endtask

    task automatic report_row();
        if (row_errors == 0) begin
            $display("test %-18s ok", row_label);
            pass_count++;
        end else begin
            $display("test %-18s %0d errors", row_label, row_errors);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Called on a falling edge and returns on the next one
    task automatic run_cycle(input logic en, input logic jmp, input fetch_pkg::addr_t jt,
                             input logic ctx, input fetch_pkg::addr_t ct, input logic srst);
        enable_i = en;
        jump_i = jmp;
        jump_target_i = jt;
        ctx_switch_i = ctx;
        ctx_switch_target_i = ct;
        sys_reset_i = srst;
        drv_en = en;
        drv_redirect = jmp || ctx;
        drv_srst = srst;
        drv_target = ctx ? {ct[31:2], 2'b00} : {jt[31:2], 2'b00};
        @(negedge clk);
        observe();
    endtask

    task automatic set_row(input int i, input string name, input logic en, input logic jmp,
                           input fetch_pkg::addr_t jt, input logic ctx, input fetch_pkg::addr_t ct,
                           input logic srst, input int hold, input fetch_pkg::addr_t exp);
        row_name[i] = name;
        row_en[i] = en;
        row_jump[i] = jmp;
        row_jt[i] = jt;
        row_ctx[i] = ctx;
        row_ct[i] = ct;
        row_srst[i] = srst;
        row_hold[i] = hold;
        row_exp[i] = exp;
    endtask

    task automatic fill_table();
        // Row, name, enable, jump, jump target, ctx, ctx target, sys_reset, cycles, next PC
        set_row(0, "reset_flow", 1, 0, 0, 0, 0, 0, 1, START);
        set_row(1, "sequential", 1, 0, 0, 0, 0, 0, 6, SEQ_PC);
        set_row(2, "jump", 1, 1, 32'h0000_2468, 0, 0, 0, 1, 32'h0000_2468);
        set_row(3, "jump_unaligned", 1, 1, 32'h0000_3007, 0, 0, 0, 1, 32'h0000_3004);
        set_row(4, "stall_short", 0, 0, 0, 0, 0, 0, 4, SEQ_PC);
        set_row(5, "priority", 1, 1, 32'h0000_4000, 1, 32'h0000_8abc, 0, 1, 32'h0000_8abc);
        set_row(6, "stall_long", 0, 0, 0, 0, 0, 0, MAX_HOLD, SEQ_PC);
        set_row(7, "ctx_switch", 1, 0, 0, 1, 32'h0001_0010, 0, 1, 32'h0001_0010);
        set_row(8, "sequential_b", 1, 0, 0, 0, 0, 0, 4, SEQ_PC);
        set_row(9, "sys_reset", 1, 0, 0, 0, 0, 1, 2, START);
        set_row(10, "stall_after_reset", 0, 0, 0, 0, 0, 0, 6, SEQ_PC);
        set_row(11, "ctx_stalled", 0, 0, 0, 1, 32'h0000_5a5c, 0, 2, 32'h0000_5a5c);
        set_row(12, "sequential_c", 1, 0, 0, 0, 0, 0, 3, SEQ_PC);
    endtask

    task automatic apply_row(input int i);
        int               hold;
        int               en_cycles;
        fetch_pkg::addr_t start_pc;
        fetch_pkg::addr_t exp_pc;
        row_label = row_name[i];
        row_errors = 0;
        start_pc = pc_o;
        hold = row_hold[i];
        if (!row_en[i]) begin
            hold = 1 + ($unsigned($random(seed)) % row_hold[i]);
        end
        en_cycles = row_en[i] ? hold : 0;
        repeat (hold) begin
            run_cycle(row_en[i], row_jump[i], row_jt[i], row_ctx[i], row_ct[i], row_srst[i]);
        end
        run_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
        while (jumping_o) begin
            run_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
        end
        exp_pc = (row_exp[i] == SEQ_PC) ? start_pc + STEP * (en_cycles + 1) : row_exp[i];
        check_value("pc_o", exp_pc, pc_o);
        check_value("instruction_o", mem_word(exp_pc), instruction_o);
        report_row();
    endtask

    initial begin
        seed = 32'h4840;
        pass_count = 0;
        fail_count = 0;
        reset_n = 1'b0;
        sys_reset_i = 1'b0;
        enable_i = 1'b0;
        jump_i = 1'b0;
        jump_target_i = '0;
        ctx_switch_i = 1'b0;
        ctx_switch_target_i = '0;
        fill_table();
        repeat (8) @(negedge clk);
        row_label = "reset";
        row_errors = 0;
        check_value("instruction_address_o", START, instruction_address_o);
        check_value("jumping_o", 32'd1, jumping_o);
        check_value("instruction_o", fetch_pkg::NOP_INSTR, instruction_o);
        check_value("pc_o", START, pc_o);
        report_row();
        last_pc = pc_o;
        last_instr = instruction_o;
        last_jumping = jumping_o;
        reset_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("Summary %0d tests ok, %0d tests with errors, %0d assertion failures",
                 pass_count, fail_count, u_dut.u_properties.assert_failures);
        if (fail_count == 0 && u_dut.u_properties.assert_failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/fetch_pkg.sv
rtl/fetch_addr_gen.sv
rtl/fetch_redirect.sv
rtl/fetch_issue.sv
rtl/fetch_top.sv
bench/fetch_properties.sv
bench/fetch_tb.sv
